// File: tests/board_comm_stim.txt
# op(hex, bit 4 set = local) dst(hex) data(hex) ack_delay(dec) extra_strobe(0/1)
# expected_read(hex, used by local reads only)
10 0 deadbeef 0 0 00000000
13 0 00000000 0 0 deadbeef
10 5 00000010 0 0 00000000
11 5 00000005 0 0 00000000
13 5 00000000 0 0 00000015
11 5 fffffff0 0 0 00000000
13 5 00000000 0 0 00000005
10 f 12345678 0 0 00000000
12 f 00000000 0 0 00000000
13 f 00000000 0 0 00000000
10 3 a5a5a5a5 0 1 00000000
13 3 00000000 0 1 a5a5a5a5
14 3 ffffffff 0 0 00000000
1f 3 11111111 0 0 00000000
17 0 22222222 0 0 00000000
13 3 00000000 0 0 a5a5a5a5
13 0 00000000 0 0 deadbeef
03 7 cafef00d 0 0 00000000
0a c 01234567 3 0 00000000
0f 1 89abcdef 7 1 00000000
00 0 00000000 1 0 00000000
05 9 ffffffff 12 0 00000000
13 7 00000000 0 0 00000000
13 c 00000000 0 0 00000000
11 2 00000001 0 0 00000000
11 2 00000001 0 1 00000000
13 2 00000000 0 0 00000002
12 0 00000000 0 0 00000000
13 0 00000000 0 0 00000000
13 5 00000000 0 1 00000005
06 3 0f0f0f0f 0 1 00000000
13 3 00000000 0 0 a5a5a5a5

// File: all.f
+incdir+src
src/board_comm_pkg.sv
src/cmd_req_ack.sv
src/loc_cmd_exec.sv
src/net_cmd_tx.sv
src/board_comm_top.sv
tests/board_comm_checker.sv
tests/tb_board_comm.sv

// File: run.sh
#!/bin/sh
# Compile and run the board_comm testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_board_comm
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f all.f --top-module tb_board_comm \
   -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./"$BUILD_DIR"/"$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
   echo "Simulation passed"
   exit 0
fi
echo "Simulation failed, see $LOG"
exit 1

// File: tests/tb_board_comm.sv
`timescale 1ns/10ps
`default_nettype none

`include "board_comm_params.svh"

module tb_board_comm;

   import board_comm_pkg::*;

   localparam int TIMEOUT_CYC = 100;
   localparam int LOCAL_LAT   = 3;

   logic                src_clk_i;
   logic                src_rst_ni;
   logic                src_vld_i;
   src_cmd_t            src_cmd_i;
   logic                net_ack_i;
   logic                rd_vld_o;
   logic [`BC_DT_W-1:0] rd_dt_o;
   logic                net_byte_vld_o;
   logic [7:0]          net_byte_o;
   logic                busy_o;
   logic [7:0]          cmd_cnt_o;
   logic [7:0]          drop_cnt_o;

   // Reference model of the bank and the counters
   logic [`BC_DT_W-1:0] bank_m [`BC_REG_NUM];
   logic [7:0]          cmd_cnt_m;
   logic [7:0]          drop_cnt_m;
   int                  err_cnt;
   int                  tmo_cnt;
   int                  cmd_total;
   integer              seed;
   logic                abort_run;

   board_comm_top u_board_comm_top (
      .src_clk_i      (src_clk_i),
      .src_rst_ni     (src_rst_ni),
      .src_vld_i      (src_vld_i),
      .src_cmd_i      (src_cmd_i),
      .net_ack_i      (net_ack_i),
      .rd_vld_o       (rd_vld_o),
      .rd_dt_o        (rd_dt_o),
      .net_byte_vld_o (net_byte_vld_o),
      .net_byte_o     (net_byte_o),
      .busy_o         (busy_o),
      .cmd_cnt_o      (cmd_cnt_o),
      .drop_cnt_o     (drop_cnt_o)
   );

   // 8 ns clock
   always #4 src_clk_i = ~src_clk_i;

   //////////////////////////////////////////////////
   // Check helpers

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      assert (got === exp) else begin
         $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_cond(input logic ok, input string what);
      assert (ok) else begin
         $display("Check failed: %s", what);
         err_cnt++;
      end
   endtask

   task automatic report_timeout(input logic done, input string what);
      assert (done) else begin
         $display("Timeout while waiting for %s", what);
         tmo_cnt++;
         abort_run = 1'b1;
      end
   endtask

   task automatic check_counters();
      check_val("cmd_cnt_o", 32'(cmd_cnt_o), 32'(cmd_cnt_m));
      check_val("drop_cnt_o", 32'(drop_cnt_o), 32'(drop_cnt_m));
   endtask

   //////////////////////////////////////////////////
   // Drive helpers

   // Step to the next falling edge, strobe lasts one cycle
   task automatic next_cycle();
      @(negedge src_clk_i);
      src_vld_i = 1'b0;
   endtask

   task automatic drive_cmd(input logic [4:0] op, input logic [3:0] dst,
                            input logic [31:0] dt);
      src_cmd_i.op  = op;
      src_cmd_i.dst = dst;
      src_cmd_i.dt  = dt;
      src_vld_i     = 1'b1;
   endtask

   // Local write with inverted data, must be dropped
   task automatic drive_drop_strobe(input logic [3:0] dst, input logic [31:0] dt);
      check_cond(busy_o, "busy_o high when the extra strobe is sent");
      drive_cmd(5'h10, dst, ~dt);
      drop_cnt_m++;
   endtask

   task automatic apply_reset();
      src_rst_ni = 1'b0;
      repeat (5) @(posedge src_clk_i);
      @(negedge src_clk_i);
      src_rst_ni = 1'b1;
   endtask

   //////////////////////////////////////////////////
   // Command sequences

   task automatic run_local_cmd(input logic [4:0] op, input logic [3:0] dst,
                                input logic [31:0] dt, input int spoil,
                                input logic [31:0] exp_rd);
      logic [3:0]  code;
      logic [31:0] old_word;
      int          cyc;
      code     = op[3:0];
      old_word = bank_m[dst];
      drive_cmd(op, dst, dt);
      cmd_cnt_m++;
      next_cycle();
      cyc = 1;
      // Read strobe one cycle after the command strobe, old word
      if (code == LOC_RD) begin
         check_val("rd_vld_o", 32'(rd_vld_o), 32'd1);
         check_val("rd_dt_o", rd_dt_o, old_word);
         check_val("rd_dt_o", rd_dt_o, exp_rd);
      end else begin
         check_val("rd_vld_o", 32'(rd_vld_o), 32'd0);
      end
      check_val("busy_o", 32'(busy_o), 32'd1);
      case (code)
         LOC_WR:  bank_m[dst] = dt;
         LOC_ADD: bank_m[dst] = bank_m[dst] + dt;
         LOC_CLR: bank_m[dst] = '0;
         default: ;
      endcase
      if (spoil != 0) begin
         drive_drop_strobe(dst, dt);
      end
      while (busy_o && cyc < TIMEOUT_CYC) begin
         next_cycle();
         cyc++;
         check_val("rd_vld_o", 32'(rd_vld_o), 32'd0);
      end
      report_timeout(!busy_o, "busy_o to fall after a local command");
      check_val("busy_o fall cycle", 32'(cyc), 32'(LOCAL_LAT));
      check_counters();
   endtask

   task automatic run_net_cmd(input logic [4:0] op, input logic [3:0] dst,
                              input logic [31:0] dt, input int dly, input int spoil);
      logic [7:0] exp_byte [`BC_PKT_BYTES];
      int         cyc;
      int         wait_cyc;
      // Op byte, then data MSB first
      exp_byte[0] = {op[3:0], dst};
      for (int k = 1; k < `BC_PKT_BYTES; k++) begin
         exp_byte[k] = dt[8*(`BC_PKT_BYTES-1-k) +: 8];
      end
      wait_cyc = dly + int'($unsigned($random(seed)) % 4);
      drive_cmd(op, dst, dt);
      cmd_cnt_m++;
      next_cycle();
      if (spoil != 0) begin
         drive_drop_strobe(dst, dt);
      end
      cyc = 0;
      while (!net_byte_vld_o && cyc < TIMEOUT_CYC) begin
         next_cycle();
         cyc++;
      end
      report_timeout(net_byte_vld_o, "the first packet byte");
      // First byte right after the request cycle
      check_val("first byte delay", 32'(cyc), 32'd0);
      for (int k = 0; k < `BC_PKT_BYTES; k++) begin
         check_val("net_byte_vld_o", 32'(net_byte_vld_o), 32'd1);
         check_val("net_byte_o", 32'(net_byte_o), 32'(exp_byte[k]));
         next_cycle();
      end
      check_val("net_byte_vld_o", 32'(net_byte_vld_o), 32'd0);

      // Link model, late acknowledge
      for (int w = 0; w < wait_cyc; w++) begin
         check_val("busy_o", 32'(busy_o), 32'd1);
         next_cycle();
      end
      check_val("busy_o", 32'(busy_o), 32'd1);
      net_ack_i = 1'b1;
      // Ack held until the request is withdrawn
      cyc = 0;
      while (u_board_comm_top.net_req && cyc < TIMEOUT_CYC) begin
         next_cycle();
         cyc++;
      end
      report_timeout(!u_board_comm_top.net_req, "net_req to fall");
      check_val("busy_o", 32'(busy_o), 32'd1);
      net_ack_i = 1'b0;
      cyc = 0;
      while (busy_o && cyc < TIMEOUT_CYC) begin
         next_cycle();
         cyc++;
      end
      report_timeout(!busy_o, "busy_o to fall after a network command");
      check_counters();
   endtask

   //////////////////////////////////////////////////
   // Main sequence

   initial begin : main_seq
      integer      fd;
      string       line;
      int          n;
      logic [31:0] f_op;
      logic [31:0] f_dst;
      logic [31:0] f_dt;
      logic [31:0] f_exp;
      int          f_dly;
      int          f_spoil;
      src_clk_i  = 1'b0;
      src_rst_ni = 1'b0;
      src_vld_i  = 1'b0;
      src_cmd_i  = '0;
      net_ack_i  = 1'b0;
      seed       = 57;
      err_cnt    = 0;
      tmo_cnt    = 0;
      cmd_total  = 0;
      abort_run  = 1'b0;
      cmd_cnt_m  = '0;
      drop_cnt_m = '0;
      for (int i = 0; i < `BC_REG_NUM; i++) begin
         bank_m[i] = '0;
      end

      apply_reset();
      // Quiet outputs after reset
      check_val("busy_o", 32'(busy_o), 32'd0);
      check_val("rd_vld_o", 32'(rd_vld_o), 32'd0);
      check_val("net_byte_vld_o", 32'(net_byte_vld_o), 32'd0);
      check_counters();

      fd = $fopen("tests/board_comm_stim.txt", "r");
      assert (fd != 0) else begin
         $display("Could not open the stimulus file");
         err_cnt++;
      end
      while (fd != 0 && !abort_run && !$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n == 0 || line.len() == 0 || line.getc(0) == "#") begin
            continue;
         end
         n = $sscanf(line, "%h %h %h %d %d %h", f_op, f_dst, f_dt, f_dly, f_spoil, f_exp);
         if (n != 6) begin
            continue;
         end
         cmd_total++;
         // Bit 4 set is a local command
         if (f_op[4]) begin
            run_local_cmd(f_op[4:0], f_dst[3:0], f_dt, f_spoil, f_exp);
         end else begin
            run_net_cmd(f_op[4:0], f_dst[3:0], f_dt, f_dly, f_spoil);
         end
      end
      if (fd != 0) begin
         $fclose(fd);
      end
      check_cond(cmd_total > 0, "stimulus file held at least one command");
      next_cycle();
      next_cycle();

      $display("Error count: %0d, timeout count: %0d", err_cnt, tmo_cnt);
      if (err_cnt == 0 && tmo_cnt == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/board_comm_checker.sv
`timescale 1ns/10ps
`default_nettype none

module board_comm_checker (
   input logic src_clk_i,
   input logic src_rst_ni,
   // Requests and acknowledges of the command block
   input logic loc_req_i,
   input logic net_req_i,
   input logic loc_ack_i,
   input logic net_ack_i,
   // Combined acknowledge after the sync chain
   input logic ack_i,
   input logic busy_i
);

   //////////////////////////////////////////////////
   // Request/acknowledge protocol

   // Never both executors at once
   req_onehot_a: assert property (@(posedge src_clk_i) disable iff (!src_rst_ni)
      !(loc_req_i && net_req_i))
      else $error("loc_req and net_req are high together");

   // Request only drops in a cycle where ack is seen
   loc_req_hold_a: assert property (@(posedge src_clk_i) disable iff (!src_rst_ni)
      $fell(loc_req_i) |-> ack_i)
      else $error("loc_req fell without an acknowledge");

   net_req_hold_a: assert property (@(posedge src_clk_i) disable iff (!src_rst_ni)
      $fell(net_req_i) |-> ack_i)
      else $error("net_req fell without an acknowledge");

   // End of the four-phase exchange
   busy_end_a: assert property (@(posedge src_clk_i) disable iff (!src_rst_ni)
      $fell(busy_i) |-> (!loc_ack_i && !net_ack_i))
      else $error("busy fell while an acknowledge was still high");

endmodule

bind cmd_req_ack board_comm_checker u_board_comm_checker (
   .src_clk_i  (src_clk_i),
   .src_rst_ni (src_rst_ni),
   .loc_req_i  (loc_req_o),
   .net_req_i  (net_req_o),
   .loc_ack_i  (loc_ack_i),
   .net_ack_i  (net_ack_i),
   .ack_i      (ack_s),
   .busy_i     (busy_o)
);

`default_nettype wire

// File: src/board_comm_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "board_comm_params.svh"

module board_comm_top (
   input  logic                     src_clk_i,
   input  logic                     src_rst_ni,
   // Command strobe
   input  logic                     src_vld_i,
   input  board_comm_pkg::src_cmd_t src_cmd_i,
   // Link acknowledge, asynchronous
   input  logic                     net_ack_i,
   // Local read return
   output logic                     rd_vld_o,
   output logic [`BC_DT_W-1:0]      rd_dt_o,
   // Packet bytes
   output logic                     net_byte_vld_o,
   output logic [7:0]               net_byte_o,
   // Status
   output logic                     busy_o,
   output logic [7:0]               cmd_cnt_o,
   output logic [7:0]               drop_cnt_o
);

   import board_comm_pkg::*;

   logic      loc_req;
   logic      net_req;
   logic      loc_ack;
   exec_cmd_t exec_cmd;

   //////////////////////////////////////////////////
   // Command acceptance and handshake

   cmd_req_ack u_cmd_req_ack (
      .src_clk_i  (src_clk_i),
      .src_rst_ni (src_rst_ni),
      .src_vld_i  (src_vld_i),
      .src_cmd_i  (src_cmd_i),
      .loc_req_o  (loc_req),
      .net_req_o  (net_req),
      .loc_ack_i  (loc_ack),
      .net_ack_i  (net_ack_i),
      .exec_cmd_o (exec_cmd),
      .busy_o     (busy_o),
      .cmd_cnt_o  (cmd_cnt_o),
      .drop_cnt_o (drop_cnt_o)
   );

   // Local register bank
   loc_cmd_exec u_loc_cmd_exec (
      .src_clk_i  (src_clk_i),
      .src_rst_ni (src_rst_ni),
      .loc_req_i  (loc_req),
      .exec_cmd_i (exec_cmd),
      .loc_ack_o  (loc_ack),
      .rd_vld_o   (rd_vld_o),
      .rd_dt_o    (rd_dt_o)
   );

   // Network packet framer
   net_cmd_tx u_net_cmd_tx (
      .src_clk_i      (src_clk_i),
      .src_rst_ni     (src_rst_ni),
      .net_req_i      (net_req),
      .exec_cmd_i     (exec_cmd),
      .net_byte_vld_o (net_byte_vld_o),
      .net_byte_o     (net_byte_o)
   );

endmodule

`default_nettype wire

// File: src/net_cmd_tx.sv
`timescale 1ns/10ps
`default_nettype none

`include "board_comm_params.svh"

module net_cmd_tx (
   input  logic                      src_clk_i,
   input  logic                      src_rst_ni,
   // Request from command block
   input  logic                      net_req_i,
   input  board_comm_pkg::exec_cmd_t exec_cmd_i,
   // Byte stream to the link
   output logic                      net_byte_vld_o,
   output logic [7:0]                net_byte_o
);

   import board_comm_pkg::*;

   localparam int PKT_W = 8 * `BC_PKT_BYTES;
   localparam int CNT_W = $clog2(`BC_PKT_BYTES + 1);

   tx_st_e           tx_st_q;
   logic             net_req_q;
   logic             req_rise_s;
   logic [PKT_W-1:0] shift_q;
   logic [CNT_W-1:0] byte_cnt_q;

   // New packet only on a fresh request
   assign req_rise_s = net_req_i & ~net_req_q;

   //////////////////////////////////////////////////
   // Framer control

   always_ff @(posedge src_clk_i) begin
      if (!src_rst_ni) begin
         net_req_q  <= 1'b0;
         tx_st_q    <= TX_IDLE;
         byte_cnt_q <= '0;
      end else begin
         net_req_q <= net_req_i;
         case (tx_st_q)
            TX_IDLE: begin
               if (req_rise_s) begin
                  tx_st_q    <= TX_SEND;
                  byte_cnt_q <= CNT_W'(`BC_PKT_BYTES);
               end
            end
            TX_SEND: begin
               byte_cnt_q <= byte_cnt_q - 1'b1;
               // Last byte on the wire this cycle
               if (byte_cnt_q == CNT_W'(1)) begin
                  tx_st_q <= TX_IDLE;
               end
            end
            default: tx_st_q <= TX_IDLE;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Shift register

   // Op byte on top, then dt MSB first
   always_ff @(posedge src_clk_i) begin
      if ((tx_st_q == TX_IDLE) && req_rise_s) begin
         shift_q <= exec_cmd_i;
      end else if (tx_st_q == TX_SEND) begin
         shift_q <= {shift_q[PKT_W-9:0], 8'h00};
      end
   end

   assign net_byte_vld_o = (tx_st_q == TX_SEND);
   assign net_byte_o     = shift_q[PKT_W-1 -: 8];

endmodule

`default_nettype wire

// File: src/loc_cmd_exec.sv
`timescale 1ns/10ps
`default_nettype none

`include "board_comm_params.svh"

module loc_cmd_exec (
   input  logic                      src_clk_i,
   input  logic                      src_rst_ni,
   // Request from command block
   input  logic                      loc_req_i,
   input  board_comm_pkg::exec_cmd_t exec_cmd_i,
   output logic                      loc_ack_o,
   // Read return
   output logic                      rd_vld_o,
   output logic [`BC_DT_W-1:0]       rd_dt_o
);

   import board_comm_pkg::*;

   logic [`BC_DT_W-1:0] bank_q [`BC_REG_NUM];
   logic                loc_ack_q;
   logic                exec_s;
   loc_op_e             op_s;
   logic [3:0]          addr_s;
   logic                rd_vld_q;
   logic [`BC_DT_W-1:0] rd_dt_q;

   // Upper nibble of op byte is the operation, lower nibble the word
   assign op_s   = loc_op_e'(exec_cmd_i.op[7:4]);
   assign addr_s = exec_cmd_i.op[3:0];

   //////////////////////////////////////////////////
   // Handshake

   // Ack follows req by one cycle
   always_ff @(posedge src_clk_i) begin
      if (!src_rst_ni) begin
         loc_ack_q <= 1'b0;
      end else begin
         loc_ack_q <= loc_req_i;
      end
   end

   // Edge where ack rises, the one execution slot
   assign exec_s = loc_req_i & ~loc_ack_q;

   //////////////////////////////////////////////////
   // Bank

   always_ff @(posedge src_clk_i) begin
      if (!src_rst_ni) begin
         for (int i = 0; i < `BC_REG_NUM; i++) begin
            bank_q[i] <= '0;
         end
      end else if (exec_s) begin
         case (op_s)
            LOC_WR:  bank_q[addr_s] <= exec_cmd_i.dt;
            // Wraps modulo word width
            LOC_ADD: bank_q[addr_s] <= bank_q[addr_s] + exec_cmd_i.dt;
            LOC_CLR: bank_q[addr_s] <= '0;
            default: ;
         endcase
      end
   end

   // Read strobe, one pulse per read command
   always_ff @(posedge src_clk_i) begin
      if (!src_rst_ni) begin
         rd_vld_q <= 1'b0;
      end else begin
         rd_vld_q <= exec_s & (op_s == LOC_RD);
      end
   end

   // Word as it was before this command
   always_ff @(posedge src_clk_i) begin
      if (exec_s && (op_s == LOC_RD)) begin
         rd_dt_q <= bank_q[addr_s];
      end
   end

   assign loc_ack_o = loc_ack_q;
   assign rd_vld_o  = rd_vld_q;
   assign rd_dt_o   = rd_dt_q;

endmodule

`default_nettype wire

// File: src/cmd_req_ack.sv
`timescale 1ns/10ps
`default_nettype none

`include "board_comm_params.svh"

module cmd_req_ack (
   input  logic                     src_clk_i,
   input  logic                     src_rst_ni,
   // Command strobe
   input  logic                     src_vld_i,
   input  board_comm_pkg::src_cmd_t src_cmd_i,
   // Executor handshake
   output logic                     loc_req_o,
   output logic                     net_req_o,
   input  logic                     loc_ack_i,
   input  logic                     net_ack_i,
   output board_comm_pkg::exec_cmd_t exec_cmd_o,
   // Status
   output logic                     busy_o,
   output logic [7:0]               cmd_cnt_o,
   output logic [7:0]               drop_cnt_o
);

   import board_comm_pkg::*;

   cmd_st_e                    cmd_st_q;
   cmd_st_e                    cmd_st_d;
   logic [`BC_SYNC_STAGES-1:0] net_ack_sync_q;
   logic                       ack_s;
   logic                       accept_s;
   exec_cmd_t                  cmd_s;
   exec_cmd_t                  cmd_q;
   logic [7:0]                 cmd_cnt_q;
   logic [7:0]                 drop_cnt_q;

   //////////////////////////////////////////////////
   // Acknowledge path

   // Link ack is asynchronous, shift through the sync chain
   always_ff @(posedge src_clk_i) begin
      if (!src_rst_ni) begin
         net_ack_sync_q <= '0;
      end else begin
         net_ack_sync_q <= {net_ack_sync_q[`BC_SYNC_STAGES-2:0], net_ack_i};
      end
   end

   // Local ack is already synchronous
   assign ack_s = loc_ack_i | net_ack_sync_q[`BC_SYNC_STAGES-1];

   //////////////////////////////////////////////////
   // Request FSM

   // Only an idle block takes a new command
   assign accept_s = src_vld_i & (cmd_st_q == IDLE);

   always_ff @(posedge src_clk_i) begin
      if (!src_rst_ni) begin
         cmd_st_q <= IDLE;
      end else begin
         cmd_st_q <= cmd_st_d;
      end
   end

   always_comb begin
      cmd_st_d  = cmd_st_q;
      loc_req_o = 1'b0;
      net_req_o = 1'b0;
      case (cmd_st_q)
         IDLE: begin
            // Request goes out in the strobe cycle
            if (src_vld_i) begin
               if (src_cmd_i.op[4]) begin
                  cmd_st_d  = LOC_REQ;
                  loc_req_o = 1'b1;
               end else begin
                  cmd_st_d  = NET_REQ;
                  net_req_o = 1'b1;
               end
            end
         end
         LOC_REQ: begin
            // Hold until ack, release in the ack cycle
            if (ack_s) begin
               cmd_st_d = ACK;
            end else begin
               loc_req_o = 1'b1;
            end
         end
         NET_REQ: begin
            if (ack_s) begin
               cmd_st_d = ACK;
            end else begin
               net_req_o = 1'b1;
            end
         end
         ACK: begin
            // Last phase, wait for ack low
            if (!ack_s) begin
               cmd_st_d = IDLE;
            end
         end
         default: cmd_st_d = IDLE;
      endcase
   end

   //////////////////////////////////////////////////
   // Command hold and counters

   assign cmd_s.op = {src_cmd_i.op[3:0], src_cmd_i.dst};
   assign cmd_s.dt = src_cmd_i.dt;

   // Held command, payload only
   always_ff @(posedge src_clk_i) begin
      if (accept_s) begin
         cmd_q <= cmd_s;
      end
   end

   always_ff @(posedge src_clk_i) begin
      if (!src_rst_ni) begin
         cmd_cnt_q  <= '0;
         drop_cnt_q <= '0;
      end else if (accept_s) begin
         cmd_cnt_q  <= cmd_cnt_q + 8'd1;
      end else if (src_vld_i) begin
         // Busy, strobe is lost
         drop_cnt_q <= drop_cnt_q + 8'd1;
      end
   end

   // Bypass in the accept cycle so executors see it with the request
   assign exec_cmd_o = accept_s ? cmd_s : cmd_q;
   assign busy_o     = (cmd_st_q != IDLE);
   assign cmd_cnt_o  = cmd_cnt_q;
   assign drop_cnt_o = drop_cnt_q;

endmodule

`default_nettype wire

// File: src/board_comm_pkg.sv
`default_nettype none

`include "board_comm_params.svh"

package board_comm_pkg;

   // Command as it arrives on the strobe
   // Bit 4 of op picks local or network
   typedef struct packed {
      logic [4:0]          op;
      logic [3:0]          dst;
      logic [`BC_DT_W-1:0] dt;
   } src_cmd_t;

   // Command as seen by the executors
   // Op byte is op[3:0] followed by dst
   typedef struct packed {
      logic [7:0]          op;
      logic [`BC_DT_W-1:0] dt;
   } exec_cmd_t;

   // Local operations, codes 4 to 15 are no-ops
   typedef enum logic [3:0] {
      LOC_WR  = 4'd0,
      LOC_ADD = 4'd1,
      LOC_CLR = 4'd2,
      LOC_RD  = 4'd3
   } loc_op_e;

   // Request/acknowledge FSM states
   typedef enum logic [1:0] {IDLE, LOC_REQ, NET_REQ, ACK} cmd_st_e;

   // Packet framer states
   typedef enum logic {TX_IDLE, TX_SEND} tx_st_e;

endpackage

`default_nettype wire

// File: src/board_comm_params.svh
`ifndef BOARD_COMM_PARAMS_SVH
`define BOARD_COMM_PARAMS_SVH

// Register bank size in words
`define BC_REG_NUM 16

// Data word width
`define BC_DT_W 32

// Flip-flops in the link acknowledge synchronizer
`define BC_SYNC_STAGES 2

// Network packet length in bytes, op byte plus data
`define BC_PKT_BYTES 5

`endif
